//--- Bender.yml
package:
  name: video_tx

sources:
  - verilog/video_pkg.sv
  - verilog/raster_timing.sv
  - verilog/pixel_credit_fifo.sv
  - verilog/tmds_encoder.sv
  - verilog/video_tx_top.sv
  - target: test
    include_dirs:
      - dv
    files:
      - dv/video_tx_tb.sv

//--- dv/video_tx_tb_tasks.svh
`ifndef VIDEO_TX_TB_TASKS_SVH
`define VIDEO_TX_TB_TASKS_SVH

string cur_test = "none";
int    test_errors;
int    total_errors = 0;
int    tests_run    = 0;

int    credits;          // Host credit counter
int    credit_seen;      // Credit pulses in the current window
int    active_seen;      // Active symbols in the current window
int    sent;
int    send_limit;       // Host stops after this many pixels
bit    ff_line;          // First line of pixels is all ones
bit    uf_seen;
int    disp [3];         // Per lane disparity from received bits
int    bit9_toggles;
logic  last_bit9;
int    ctrl_seen [4];    // Blanking characters seen per {vsync,hsync}
rgb_t  tx_q [$];
rgb_t  rx_q [$];

function automatic int ones10(input tmds_sym_t s);
    int n;
    n = 0;
    for (int i = 0; i < 10; i++) begin
        n += s[i];
    end
    return n;
endfunction

// Undo inversion with bit 9, then unchain with XOR or XNOR per bit 8
function automatic logic [7:0] decode_sym(input tmds_sym_t s);
    logic [7:0] d;
    logic [7:0] o;
    d    = s[9] ? ~s[7:0] : s[7:0];
    o[0] = d[0];
    for (int i = 1; i < 8; i++) begin
        o[i] = s[8] ? (d[i] ^ d[i-1]) : ~(d[i] ^ d[i-1]);
    end
    return o;
endfunction

function automatic rgb_t make_pixel(input int idx);
    if (ff_line && idx < H_ACTIVE) begin
        return 24'hffffff;
    end
    return rgb_t'($urandom());
endfunction

task automatic fail_value(input string what, input logic [31:0] exp, input logic [31:0] act);
    $display("Fail %s %s expected %h actual %h", cur_test, what, exp, act);
    test_errors++;
endtask

task automatic note_problem(input string what);
    $display("Error in %s: %s", cur_test, what);
    test_errors++;
endtask

task automatic start_test(input string name);
    cur_test    = name;
    test_errors = 0;
endtask

task automatic end_test();
    tests_run++;
    total_errors += test_errors;
    $display("Test %s done, %0d errors", cur_test, test_errors);
endtask

// Samples the DUT outputs at the falling edge
task automatic observe();
    tmds_sym_t lane [3];
    rgb_t      px;
    lane[0] = tmds.ch0;
    lane[1] = tmds.ch1;
    lane[2] = tmds.ch2;
    if (pix_credit) begin
        credits++;
        credit_seen++;
    end
    if (credits > FIFO_DEPTH || credits < 0) note_problem("host credit count out of range");
    if (uf_seen && !underflow) note_problem("underflow flag dropped after rising");
    if (underflow) uf_seen = 1'b1;
    if (sync_out.de) begin
        px.b = decode_sym(lane[0]);
        px.g = decode_sym(lane[1]);
        px.r = decode_sym(lane[2]);
        rx_q.push_back(px);
        active_seen++;
        for (int k = 0; k < 3; k++) begin
            disp[k] += 2 * ones10(lane[k]) - 10;   // Ones minus zeros
            if (disp[k] > 8 || disp[k] < -8) fail_value("disparity", 8, disp[k]);
        end
        if (active_seen <= H_ACTIVE) begin   // First line only
            if (active_seen > 1 && lane[0][9] != last_bit9) bit9_toggles++;
            last_bit9 = lane[0][9];
        end
    end else begin
        disp = '{0, 0, 0};   // Balance restarts in blanking
        if (tmds.ch0 != CTRL[{sync_out.vsync, sync_out.hsync}]) begin
            fail_value("ch0 ctrl", CTRL[{sync_out.vsync, sync_out.hsync}], tmds.ch0);
        end
        if (tmds.ch1 != CTRL[0]) fail_value("ch1 ctrl", CTRL[0], tmds.ch1);
        if (tmds.ch2 != CTRL[0]) fail_value("ch2 ctrl", CTRL[0], tmds.ch2);
        ctrl_seen[{sync_out.vsync, sync_out.hsync}]++;
    end
endtask

// Host model that sends only while it holds a credit
task automatic drive();
    pix_valid = 1'b0;
    pix       = '0;
    if (sent < send_limit && credits > 0) begin
        pix       = make_pixel(sent);
        pix_valid = 1'b1;
        credits--;
        sent++;
        tx_q.push_back(pix);
    end
endtask

task automatic step();
    @(negedge clk);
    observe();
    drive();
endtask

// Host drives from the release edge so the FIFO is fed before the first pop
task automatic reset_dut(input int limit);
    arst_n    = 1'b0;
    pix_valid = 1'b0;
    pix       = '0;
    repeat (16) @(negedge clk);
    credits      = FIFO_DEPTH;
    sent         = 0;
    send_limit   = limit;
    credit_seen  = 0;
    active_seen  = 0;
    uf_seen      = 1'b0;
    disp         = '{0, 0, 0};
    bit9_toggles = 0;
    ctrl_seen    = '{0, 0, 0, 0};
    tx_q.delete();
    rx_q.delete();
    arst_n = 1'b1;
    drive();
endtask

task automatic test_reset_state();
    start_test("reset_state");
    reset_dut(0);
    if (sync_out !== '0) fail_value("sync_out", 0, sync_out);
    if (underflow !== 1'b0) fail_value("underflow", 0, underflow);
    if (pix_credit !== 1'b0) fail_value("pix_credit", 0, pix_credit);
    if (tmds.ch0 !== CTRL[0]) fail_value("ch0", CTRL[0], tmds.ch0);
    if (tmds.ch1 !== CTRL[0]) fail_value("ch1", CTRL[0], tmds.ch1);
    if (tmds.ch2 !== CTRL[0]) fail_value("ch2", CTRL[0], tmds.ch2);
    end_test();
endtask

task automatic test_credits();
    int n;
    start_test("credits");
    reset_dut(0);
    n = 0;
    while (!sync_out.vsync) begin   // Park in vertical blanking
        if (n > 2 * FRAME) abort_run("no vsync seen");
        n++;
        step();
    end
    send_limit = FIFO_DEPTH;
    sent       = 0;
    repeat (FIFO_DEPTH) step();
    if (credits != 0) fail_value("credits after fill", 0, credits);
    credit_seen = 0;
    n = 0;
    while (!sync_out.de) begin   // No pops, so no credits yet
        if (credit_seen != 0) fail_value("early credits", 0, credit_seen);
        if (n > 2 * FRAME) abort_run("no active video seen");
        n++;
        step();
    end
    send_limit  = 1 << 30;
    credit_seen = 0;
    active_seen = 0;
    repeat (FRAME) step();
    if (credit_seen != active_seen) fail_value("credits vs pops", active_seen, credit_seen);
    if (active_seen != ACTIVE_PIX) fail_value("pops", ACTIVE_PIX, active_seen);
    end_test();
endtask

task automatic test_round_trip();
    start_test("round_trip");
    reset_dut(1 << 30);
    repeat (2 * FRAME) step();
    if (rx_q.size() != 2 * ACTIVE_PIX) fail_value("pixel count", 2 * ACTIVE_PIX, rx_q.size());
    for (int i = 0; i < rx_q.size() && i < tx_q.size(); i++) begin
        if (rx_q[i] != tx_q[i]) fail_value("pixel", tx_q[i], rx_q[i]);
    end
    if (underflow) fail_value("underflow", 0, underflow);
    end_test();
endtask

task automatic test_control_symbols();
    int exp_cnt [4];
    start_test("control_symbols");
    // Blanking cycles per frame for each {vsync,hsync}
    exp_cnt[0] = (V_TOTAL - V_SYNC) * (H_TOTAL - H_SYNC) - ACTIVE_PIX;
    exp_cnt[1] = (V_TOTAL - V_SYNC) * H_SYNC;   // hsync only
    exp_cnt[2] = V_SYNC * (H_TOTAL - H_SYNC);   // vsync only
    exp_cnt[3] = V_SYNC * H_SYNC;
    reset_dut(1 << 30);
    repeat (FRAME) step();   // Per-cycle checks run inside observe
    for (int k = 0; k < 4; k++) begin
        if (ctrl_seen[k] != exp_cnt[k]) fail_value("sync cycles", exp_cnt[k], ctrl_seen[k]);
    end
    end_test();
endtask

task automatic test_dc_balance();
    start_test("dc_balance");
    ff_line = 1'b1;
    reset_dut(1 << 30);
    repeat (FRAME) step();
    ff_line = 1'b0;
    if (bit9_toggles < H_ACTIVE / 2) fail_value("bit9 toggles", H_ACTIVE / 2, bit9_toggles);
    for (int i = 0; i < H_ACTIVE && i < rx_q.size(); i++) begin
        if (rx_q[i] != 24'hffffff) fail_value("white pixel", 24'hffffff, rx_q[i]);
    end
    end_test();
endtask

task automatic test_underflow();
    rgb_t exp;
    start_test("underflow");
    reset_dut(5);   // Host runs out well before the first line ends
    repeat (FRAME) step();
    if (!underflow) fail_value("underflow", 1, underflow);
    if (rx_q.size() != ACTIVE_PIX) fail_value("pixel count", ACTIVE_PIX, rx_q.size());
    for (int i = 0; i < rx_q.size(); i++) begin
        exp = (i < tx_q.size()) ? tx_q[i] : '0;   // Black after the last write
        if (rx_q[i] != exp) fail_value("pixel", exp, rx_q[i]);
    end
    end_test();
endtask

`endif

//--- dv/video_tx_tb.sv
`timescale 1ns/100ps

module video_tx_tb;
    import video_pkg::*;

    // Small raster so a whole frame runs in a few microseconds
    localparam int H_ACTIVE   = 8;
    localparam int H_FRONT    = 2;
    localparam int H_SYNC     = 3;
    localparam int H_BACK     = 3;
    localparam int V_ACTIVE   = 4;
    localparam int V_FRONT    = 1;
    localparam int V_SYNC     = 2;
    localparam int V_BACK     = 1;
    localparam int FIFO_DEPTH = 8;
    localparam bit LEGACY     = 1'b0;

    localparam int H_TOTAL    = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;
    localparam int V_TOTAL    = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;
    localparam int FRAME      = H_TOTAL * V_TOTAL;      // Clocks per frame
    localparam int ACTIVE_PIX = H_ACTIVE * V_ACTIVE;    // Pixels per frame

    // Expected control characters, same build choice as the DUT
    localparam ctrl_table_t CTRL = LEGACY ? CTRL_DVI : CTRL_HDMI;

    logic        clk;
    logic        arst_n;
    logic        pix_valid;
    rgb_t        pix;
    logic        pix_credit;
    logic        underflow;
    tmds_lanes_t tmds;
    sync_t       sync_out;

    video_tx_top #(
        .H_ACTIVE           (H_ACTIVE),
        .H_FRONT            (H_FRONT),
        .H_SYNC             (H_SYNC),
        .H_BACK             (H_BACK),
        .V_ACTIVE           (V_ACTIVE),
        .V_FRONT            (V_FRONT),
        .V_SYNC             (V_SYNC),
        .V_BACK             (V_BACK),
        .FIFO_DEPTH         (FIFO_DEPTH),
        .LEGACY_DVI_CONTROL (LEGACY)
    ) i_dut (
        .clk        (clk),
        .arst_n     (arst_n),
        .pix_valid  (pix_valid),
        .pix        (pix),
        .pix_credit (pix_credit),
        .underflow  (underflow),
        .tmds       (tmds),
        .sync_out   (sync_out)
    );

    always #20 clk = ~clk;   // 40 ns period

    `include "video_tx_tb_tasks.svh"

    // Ends the run at once, used when a wait loop times out
    task automatic abort_run(input string why);
        $display("Timeout in %s: %s", cur_test, why);
        $display("** FAIL **");
        $finish;
    endtask

    initial begin
        clk       = 1'b0;
        arst_n    = 1'b0;
        pix_valid = 1'b0;
        pix       = '0;
        void'($urandom(32'hb32c));   // Fixed seed for the whole run

        test_reset_state();
        test_credits();
        test_round_trip();
        test_control_symbols();
        test_dc_balance();
        test_underflow();

        $display("Summary: %0d tests run, %0d errors", tests_run, total_errors);
        if (total_errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

//--- src.f
+incdir+dv
verilog/video_pkg.sv
verilog/raster_timing.sv
verilog/pixel_credit_fifo.sv
verilog/tmds_encoder.sv
verilog/video_tx_top.sv
dv/video_tx_tb.sv

//--- verilog/pixel_credit_fifo.sv
`timescale 1ns/100ps

module pixel_credit_fifo #(
    parameter int FIFO_DEPTH = 16
) (
    input  logic            clk,
    input  logic            arst_n,
    input  logic            wr_en,
    input  video_pkg::rgb_t wr_data,
    input  logic            rd_en,
    output video_pkg::rgb_t rd_data,
    output logic            empty,
    output logic            credit,
    output logic            underflow
);
    import video_pkg::*;

    localparam int AW = $clog2(FIFO_DEPTH);

    // Pointer wrap logic relies on a power-of-two depth
    if (FIFO_DEPTH != (1 << AW)) begin : g_depth_check
        $error("pixel_credit_fifo: FIFO_DEPTH must be a power of two");
    end

    rgb_t        mem [FIFO_DEPTH];
    logic [AW:0] wr_ptr;   // Extra MSB tells full from empty
    logic [AW:0] rd_ptr;
    logic        full;
    logic        pop;

    assign empty = (wr_ptr == rd_ptr);
    assign full  = (wr_ptr == {~rd_ptr[AW], rd_ptr[AW-1:0]});   // Same slot, other lap
    assign pop   = rd_en && !empty;

    // Show-ahead read keeps the head entry on the output
    assign rd_data = mem[rd_ptr[AW-1:0]];

    // Pixel storage
    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_ptr[AW-1:0]] <= wr_data;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr <= wr_ptr + 1'b1;   // Host never writes while full
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    // One credit per freed entry, one cycle after the pop
    // Underflow is sticky until the next reset
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            credit    <= 1'b0;
            underflow <= 1'b0;
        end else begin
            credit <= pop;
            if (rd_en && empty) begin
                underflow <= 1'b1;
            end
        end
    end

    // Host side credit rule broken if this fires
    a_no_write_full: assert property (
        @(posedge clk) disable iff (!arst_n)
        wr_en |-> !full
    ) else $error("write while FIFO full");

endmodule

//--- verilog/raster_timing.sv
`timescale 1ns/100ps

module raster_timing #(
    parameter int H_ACTIVE = 640,
    parameter int H_FRONT  = 16,
    parameter int H_SYNC   = 96,
    parameter int H_BACK   = 48,
    parameter int V_ACTIVE = 480,
    parameter int V_FRONT  = 10,
    parameter int V_SYNC   = 2,
    parameter int V_BACK   = 33
) (
    input  logic             clk,
    input  logic             arst_n,
    output video_pkg::sync_t timing
);
    import video_pkg::*;

    // Line and frame lengths in pixel clocks / lines
    localparam int H_TOTAL = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;
    localparam int V_TOTAL = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;
    localparam int HW      = $clog2(H_TOTAL);
    localparam int VW      = $clog2(V_TOTAL);

    // Sync pulse windows with inclusive start and exclusive end
    localparam int HS_START = H_ACTIVE + H_FRONT;
    localparam int HS_END   = HS_START + H_SYNC;
    localparam int VS_START = V_ACTIVE + V_FRONT;
    localparam int VS_END   = VS_START + V_SYNC;

    logic [HW-1:0] col;   // Pixel position inside the line
    logic [VW-1:0] row;   // Line position inside the frame
    sync_t         timing_nxt;

    // Column wraps every line and steps the row counter
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            col <= '0;
            row <= '0;
        end else if (col == HW'(H_TOTAL - 1)) begin
            col <= '0;
            if (row == VW'(V_TOTAL - 1)) begin
                row <= '0;   // New frame
            end else begin
                row <= row + 1'b1;
            end
        end else begin
            col <= col + 1'b1;
        end
    end

    // Decode the counter position against the window bounds
    always_comb begin
        timing_nxt.hsync = (col >= HW'(HS_START)) && (col < HW'(HS_END));
        timing_nxt.vsync = (row >= VW'(VS_START)) && (row < VW'(VS_END));
        timing_nxt.de    = (col < HW'(H_ACTIVE)) && (row < VW'(V_ACTIVE));
    end

    // Registered outputs trail the counters by one cycle
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            timing <= '0;
        end else begin
            timing <= timing_nxt;
        end
    end

endmodule

//--- verilog/tmds_encoder.sv
`timescale 1ns/100ps

module tmds_encoder #(
    parameter bit LEGACY_DVI_CONTROL = 1'b0
) (
    input  logic                 clk,
    input  logic                 arst_n,
    input  logic                 de,
    input  logic [7:0]           d,
    input  logic                 c0,
    input  logic                 c1,
    output video_pkg::tmds_sym_t q_out
);
    import video_pkg::*;

    // Control character table picked at build time
    localparam ctrl_table_t CTRL = LEGACY_DVI_CONTROL ? CTRL_DVI : CTRL_HDMI;

    // Number of ones in a byte
    function automatic logic [3:0] ones8(input logic [7:0] v);
        logic [3:0] n;
        n = '0;
        for (int i = 0; i < 8; i++) begin
            n = n + v[i];
        end
        return n;
    endfunction

    logic [3:0]        n1_d;       // Ones in the input byte
    logic              use_xnor;
    logic [8:0]        q_m;        // Transition-minimized word
    logic [3:0]        n1_qm;
    logic signed [5:0] bal;        // Ones minus zeros of q_m[7:0]
    logic signed [5:0] disp;       // Running disparity
    logic signed [5:0] disp_nxt;
    tmds_sym_t         sym_nxt;

    // Stage 1, pick XOR or XNOR chaining to cut transitions
    always_comb begin
        n1_d     = ones8(d);
        use_xnor = (n1_d > 4'd4) || ((n1_d == 4'd4) && !d[0]);
        q_m[0]   = d[0];
        for (int i = 1; i < 8; i++) begin
            q_m[i] = use_xnor ? ~(q_m[i-1] ^ d[i]) : (q_m[i-1] ^ d[i]);
        end
        q_m[8] = ~use_xnor;   // 1 = XOR chain
    end

    // Stage 2, DC balance against the running disparity
    always_comb begin
        n1_qm = ones8(q_m[7:0]);
        bal   = $signed({1'b0, n1_qm, 1'b0}) - 6'sd8;   // 2*N1 - 8
        if ((disp == 6'sd0) || (bal == 6'sd0)) begin
            // No bias either way, bit 9 just mirrors the chain type
            sym_nxt[9]   = ~q_m[8];
            sym_nxt[8]   = q_m[8];
            sym_nxt[7:0] = q_m[8] ? q_m[7:0] : ~q_m[7:0];
            disp_nxt     = q_m[8] ? (disp + bal) : (disp - bal);
        end else if (((disp > 6'sd0) && (bal > 6'sd0)) ||
                     ((disp < 6'sd0) && (bal < 6'sd0))) begin
            // Word would push further the same way, invert it
            sym_nxt[9]   = 1'b1;
            sym_nxt[8]   = q_m[8];
            sym_nxt[7:0] = ~q_m[7:0];
            disp_nxt     = disp - bal + (q_m[8] ? 6'sd2 : 6'sd0);
        end else begin
            sym_nxt[9]   = 1'b0;
            sym_nxt[8]   = q_m[8];
            sym_nxt[7:0] = q_m[7:0];
            disp_nxt     = disp + bal - (q_m[8] ? 6'sd0 : 6'sd2);
        end
    end

    // Output register, control characters during blanking
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            q_out <= CTRL[2'b00];
            disp  <= '0;
        end else if (de) begin
            q_out <= sym_nxt;
            disp  <= disp_nxt;
        end else begin
            q_out <= CTRL[{c1, c0}];   // hsync/vsync on channel 0 only
            disp  <= '0;               // Balance restarts each active run
        end
    end

    // Algorithm bound on the running disparity
    a_disp_bounded: assert property (
        @(posedge clk) disable iff (!arst_n)
        (disp <= 6'sd8) && (disp >= -6'sd8)
    ) else $error("running disparity out of range: %0d", disp);

endmodule

//--- verilog/video_pkg.sv
package video_pkg;

    // One 24-bit host pixel, red in the top byte
    typedef struct packed {
        logic [7:0] r;
        logic [7:0] g;
        logic [7:0] b;
    } rgb_t;

    // Raster control bits, active high
    typedef struct packed {
        logic hsync;
        logic vsync;
        logic de;     // Display enable, high during active video
    } sync_t;

    // One TMDS character, bit 0 is sent first on the wire
    typedef logic [9:0] tmds_sym_t;

    // Three lanes of one pixel clock
    typedef struct packed {
        tmds_sym_t ch2;   // Red
        tmds_sym_t ch1;   // Green
        tmds_sym_t ch0;   // Blue, also carries hsync/vsync in blanking
    } tmds_lanes_t;

    // Four control characters, indexed by {c1,c0}
    typedef tmds_sym_t [3:0] ctrl_table_t;

    // HDMI control period characters
    // Entry order in the literal is 11, 10, 01, 00
    localparam ctrl_table_t CTRL_HDMI = {
        10'b1010101011,   // {c1,c0} = 11
        10'b0101010100,   // 10
        10'b0010101011,   // 01
        10'b1101010100    // 00
    };

    // Legacy DVI characters, bit order as used by older sinks
    localparam ctrl_table_t CTRL_DVI = {
        10'b1101010101,   // {c1,c0} = 11
        10'b0010101010,   // 10
        10'b1101010100,   // 01
        10'b0010101011    // 00
    };

endpackage

//--- verilog/video_tx_top.sv
`timescale 1ns/100ps

module video_tx_top #(
    parameter int H_ACTIVE           = 640,
    parameter int H_FRONT            = 16,
    parameter int H_SYNC             = 96,
    parameter int H_BACK             = 48,
    parameter int V_ACTIVE           = 480,
    parameter int V_FRONT            = 10,
    parameter int V_SYNC             = 2,
    parameter int V_BACK             = 33,
    parameter int FIFO_DEPTH         = 16,
    parameter bit LEGACY_DVI_CONTROL = 1'b0
) (
    input  logic                   clk,
    input  logic                   arst_n,
    input  logic                   pix_valid,
    input  video_pkg::rgb_t        pix,
    output logic                   pix_credit,
    output logic                   underflow,
    output video_pkg::tmds_lanes_t tmds,
    output video_pkg::sync_t       sync_out
);
    import video_pkg::*;

    sync_t timing;       // Raster state for the current pixel slot
    rgb_t  pix_rd;       // FIFO head
    rgb_t  pix_enc;      // Pixel fed to the encoders
    logic  fifo_empty;

    raster_timing #(
        .H_ACTIVE (H_ACTIVE), .H_FRONT (H_FRONT), .H_SYNC (H_SYNC), .H_BACK (H_BACK),
        .V_ACTIVE (V_ACTIVE), .V_FRONT (V_FRONT), .V_SYNC (V_SYNC), .V_BACK (V_BACK)
    ) i_timing (
        .clk    (clk),
        .arst_n (arst_n),
        .timing (timing)
    );

    // Pops once per active pixel slot
    pixel_credit_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) i_fifo (
        .clk       (clk),
        .arst_n    (arst_n),
        .wr_en     (pix_valid),
        .wr_data   (pix),
        .rd_en     (timing.de),
        .rd_data   (pix_rd),
        .empty     (fifo_empty),
        .credit    (pix_credit),
        .underflow (underflow)
    );

    // Black when the FIFO has run dry
    assign pix_enc = fifo_empty ? '0 : pix_rd;

    tmds_encoder #(.LEGACY_DVI_CONTROL (LEGACY_DVI_CONTROL)) i_enc_b (
        .clk (clk), .arst_n (arst_n), .de (timing.de), .d (pix_enc.b),
        .c0 (timing.hsync), .c1 (timing.vsync), .q_out (tmds.ch0)
    );

    tmds_encoder #(.LEGACY_DVI_CONTROL (LEGACY_DVI_CONTROL)) i_enc_g (
        .clk (clk), .arst_n (arst_n), .de (timing.de), .d (pix_enc.g),
        .c0 (1'b0), .c1 (1'b0), .q_out (tmds.ch1)
    );

    tmds_encoder #(.LEGACY_DVI_CONTROL (LEGACY_DVI_CONTROL)) i_enc_r (
        .clk (clk), .arst_n (arst_n), .de (timing.de), .d (pix_enc.r),
        .c0 (1'b0), .c1 (1'b0), .q_out (tmds.ch2)
    );

    // Match the encoder latency so sync_out lines up with tmds
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            sync_out <= '0;
        end else begin
            sync_out <= timing;
        end
    end

endmodule
